//--- sources.f
+incdir+include
source/anpc_state_pkg.sv
source/anpc_timing_pkg.sv
source/commutation_table.sv
source/dwell_timer.sv
source/commutation_ctrl.sv
source/anpc_leg_top.sv
test/anpc_leg_tb.sv

//--- Bender.yml
package:
  name: anpc_leg

sources:
  - include_dirs:
      - include
    files:
      - source/anpc_state_pkg.sv
      - source/anpc_timing_pkg.sv
      - source/commutation_table.sv
      - source/dwell_timer.sv
      - source/commutation_ctrl.sv
      - source/anpc_leg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/anpc_leg_tb.sv

//--- test/anpc_leg_tb.sv
`timescale 1ns/100ps
`include "anpc_settings.svh"

module anpc_leg_tb import anpc_state_pkg::*; ();

    localparam int RESET_CYCLES = 5;
    localparam int N_REQ        = 200;
    localparam int MAX_STEPS    = 4;
    localparam int MAX_DWELL    = 8;   // Bound of a 3-bit draw
    localparam int CYCLE_LIMIT  = N_REQ * (2 + MAX_STEPS * MAX_DWELL) + RESET_CYCLES;

    localparam logic [2:0] SH = 3'd0;  // short
    localparam logic [2:0] OO = 3'd1;  // off_on
    localparam logic [2:0] V0 = 3'd2;  // on_off_v0
    localparam logic [2:0] VN = 3'd3;  // off_v0_on
    localparam logic [2:0] I0 = 3'd4;  // off_on_i0

    logic                       clk;
    logic                       rst;
    logic                       req;
    leg_state_t                 target;
    logic [`TDELAY_WIDTH-1:0]   t_short;
    logic [`TDELAY_WIDTH-1:0]   t_off_on;
    logic [`TDELAY_WIDTH-1:0]   t_on_off_v0;
    logic [`TDELAY_WIDTH-1:0]   t_off_v0_on;
    logic [`TDELAY_WIDTH-1:0]   t_off_on_i0;
    logic                       ack;
    logic                       rejected;
    leg_state_t                 state;
    logic [`SWITCH_COUNT-1:0]   gates;

    logic                       exp_ack;       // Reference model outputs
    logic                       exp_rejected;
    leg_state_t                 exp_state;
    logic [`SWITCH_COUNT-1:0]   exp_gates;
    logic                       busy;          // Commutation in flight
    logic                       no_seq;
    leg_state_t                 req_to;
    int                         elapsed;       // Edges since req was sampled
    int                         edge_at;
    int                         seq_len;
    logic [38:0]                sq;
    logic [`SWITCH_COUNT-1:0]   seq_pat [MAX_STEPS];
    int                         seq_dw [MAX_STEPS];
    bit                         covered [6][6];  // Indexed by target, source
    logic [15:0]                lfsr;
    int                         cycles;

    // Tour through all fourteen pairs, then a same-state and a refused request
    leg_state_t directed [19] = '{P, Z_L1, P, Z_L2, P, Z_U2, N, Z_U1, N, Z_L2,
                                  N, Z_U2, N, Z_U1, P, Z_L1, N, N, P};

    anpc_leg_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .target      (target),
        .t_short     (t_short),
        .t_off_on    (t_off_on),
        .t_on_off_v0 (t_on_off_v0),
        .t_off_v0_on (t_off_v0_on),
        .t_off_on_i0 (t_off_on_i0),
        .ack         (ack),
        .rejected    (rejected),
        .state       (state),
        .gates       (gates)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [`TDELAY_WIDTH-1:0] draw_dwell();
        int v;
        v = take_bits(3);
        return (v == 0) ? 1 : v;  // Zero dwell not allowed
    endfunction

    function automatic int dwell_for(input logic [2:0] k);
        case (k)
            OO:      return t_off_on;
            V0:      return t_on_off_v0;
            VN:      return t_off_v0_on;
            I0:      return t_off_on_i0;
            default: return t_short;
        endcase
    endfunction

    // Step count, then pattern and dwell kind per step
    function automatic logic [38:0] sequence_of(input leg_state_t to, input leg_state_t from);
        case ({to, from})
            {P, Z_U2}:    return {3'd3, 6'b010000, OO, 6'b110000, SH, 6'b110001, SH, 9'd0};
            {P, Z_U1}:    return {3'd4, 6'b010010, I0, 6'b010011, SH,
                                  6'b010001, OO, 6'b110001, SH};
            {P, Z_L1}:    return {3'd2, 6'b100001, OO, 6'b110001, SH, 18'd0};
            {P, Z_L2}:    return {3'd3, 6'b011001, SH, 6'b010001, OO, 6'b110001, SH, 9'd0};
            {Z_U2, P}:    return {3'd3, 6'b110000, SH, 6'b010000, OO, 6'b010010, SH, 9'd0};
            {Z_U2, N}:    return {3'd3, 6'b001010, OO, 6'b011010, V0, 6'b010010, V0, 9'd0};
            {Z_U1, N}:    return {3'd2, 6'b000110, OO, 6'b010110, SH, 18'd0};
            {Z_L1, P}:    return {3'd2, 6'b100001, OO, 6'b101001, SH, 18'd0};
            {Z_L2, P}:    return {3'd3, 6'b010001, OO, 6'b011001, V0, 6'b001001, VN, 9'd0};
            {Z_L2, N}:    return {3'd3, 6'b001100, SH, 6'b001000, OO, 6'b001001, SH, 9'd0};
            {N, Z_U2}:    return {3'd3, 6'b011010, SH, 6'b001010, OO, 6'b001110, SH, 9'd0};
            {N, Z_U1}:    return {3'd2, 6'b000110, OO, 6'b001110, SH, 18'd0};
            {N, Z_L1}:    return {3'd4, 6'b001001, I0, 6'b001011, SH,
                                  6'b001010, OO, 6'b001110, SH};
            {N, Z_L2}:    return {3'd3, 6'b001000, OO, 6'b001100, SH, 6'b001110, SH, 9'd0};
            default:      return '0;  // No sequence
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input int expected, input int actual);
        stop_on_error($sformatf("MISMATCH at %0t: %s expected %0h, actual %0h",
                                $time, name, expected, actual));
    endtask

    // Full four-phase handshake for one target
    task automatic request_state(input leg_state_t next);
        t_short     <= draw_dwell();
        t_off_on    <= draw_dwell();
        t_on_off_v0 <= draw_dwell();
        t_off_v0_on <= draw_dwell();
        t_off_on_i0 <= draw_dwell();
        target      <= next;
        req         <= 1'b1;
        do @(posedge clk); while (ack !== 1'b1);
        req <= 1'b0;
        do @(posedge clk); while (ack !== 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            exp_ack      <= 1'b0;
            exp_rejected <= 1'b0;
            exp_state    <= Z_U2;
            exp_gates    <= `RESET_GATES;
            busy         = 1'b0;
            elapsed      = 0;
        end else if (busy) begin
            elapsed = elapsed + 1;
            edge_at = 1;  // Step 0 shows one edge after the request
            for (int k = 0; k < seq_len; k++) begin
                if (elapsed == edge_at)
                    exp_gates <= seq_pat[k];
                edge_at = edge_at + seq_dw[k];
            end
            if (elapsed == edge_at) begin
                exp_ack      <= 1'b1;
                exp_rejected <= no_seq;
                if (seq_len != 0)
                    exp_state <= req_to;
                busy = 1'b0;
            end
        end else if (exp_ack) begin
            if (!req) begin
                exp_ack      <= 1'b0;
                exp_rejected <= 1'b0;
            end
        end else if (req) begin
            req_to  = target;
            sq      = sequence_of(target, exp_state);
            no_seq  = (target != exp_state) && (sq[38:36] == 3'd0);
            seq_len = (target == exp_state) ? 0 : sq[38:36];
            for (int k = 0; k < MAX_STEPS; k++) begin
                seq_pat[k] = sq[35 - 9 * k -: 6];
                seq_dw[k]  = dwell_for(sq[29 - 9 * k -: 3]);
            end
            if (seq_len != 0)
                covered[target][exp_state] = 1'b1;
            busy    = 1'b1;
            elapsed = 0;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
            stop_on_error("Timeout: requests did not finish within the cycle limit");
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    a_ack_match: assert property (@(posedge clk) disable iff (rst) ack == exp_ack)
        else value_mismatch("ack", $sampled(exp_ack), $sampled(ack));

    a_rejected_match: assert property (@(posedge clk) disable iff (rst)
        rejected == exp_rejected)
        else value_mismatch("rejected", $sampled(exp_rejected), $sampled(rejected));

    a_state_match: assert property (@(posedge clk) disable iff (rst) state == exp_state)
        else value_mismatch("state", int'($sampled(exp_state)), int'($sampled(state)));

    a_gates_match: assert property (@(posedge clk) disable iff (rst) gates == exp_gates)
        else value_mismatch("gates", $sampled(exp_gates), $sampled(gates));

    a_single_switch: assert property (@(posedge clk) disable iff (rst)
        $countones(gates ^ $past(gates)) <= 1)
        else stop_on_error("More than one gate switched at one clock edge");

    initial begin
        int code;
        int pairs;
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        target      = Z_U2;
        t_short     = 1;
        t_off_on    = 1;
        t_on_off_v0 = 1;
        t_off_v0_on = 1;
        t_off_on_i0 = 1;
        lfsr        = 16'd19;
        cycles      = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (directed[i])
            request_state(directed[i]);
        for (int i = $size(directed); i < N_REQ; i++) begin
            code = take_bits(3);
            if (code > 5)
                code = code - 6;  // Fold onto the six states
            request_state(leg_state_t'(code));
        end
        pairs = 0;
        foreach (covered[t, f])
            pairs = pairs + covered[t][f];
        if (pairs != 14) begin
            stop_on_error($sformatf("Only %0d of 14 commutation pairs were exercised", pairs));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- source/anpc_leg_top.sv
`timescale 1ns/100ps
`include "anpc_settings.svh"

module anpc_leg_top import anpc_state_pkg::*, anpc_timing_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  leg_state_t                 target,
    input  logic [`TDELAY_WIDTH-1:0]   t_short,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_on,
    input  logic [`TDELAY_WIDTH-1:0]   t_on_off_v0,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_v0_on,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_on_i0,
    output logic                       ack,
    output logic                       rejected,
    output leg_state_t                 state,
    output logic [`SWITCH_COUNT-1:0]   gates
);

    leg_state_t                 from_state;
    leg_state_t                 to_state;
    logic [`STEP_WIDTH-1:0]     step;
    logic [`SWITCH_COUNT-1:0]   pattern;
    dwell_kind_t                kind;     // Kind of the looked-up step
    dwell_kind_t                kind_sel; // Kind handed to the timer
    logic                       last;
    logic                       valid;
    logic                       load;
    logic                       expired;

    commutation_table table0 (
        .from_state (from_state),
        .to_state   (to_state),
        .step       (step),
        .pattern    (pattern),
        .kind       (kind),
        .last       (last),
        .valid      (valid)
    );

    dwell_timer timer0 (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .kind        (kind_sel),
        .t_short     (t_short),
        .t_off_on    (t_off_on),
        .t_on_off_v0 (t_on_off_v0),
        .t_off_v0_on (t_off_v0_on),
        .t_off_on_i0 (t_off_on_i0),
        .expired     (expired)
    );

    commutation_ctrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .target     (target),
        .ack        (ack),
        .rejected   (rejected),
        .state      (state),
        .gates      (gates),
        .from_state (from_state),
        .to_state   (to_state),
        .step       (step),
        .pattern    (pattern),
        .kind       (kind),
        .last       (last),
        .valid      (valid),
        .load       (load),
        .kind_sel   (kind_sel),
        .expired    (expired)
    );

endmodule

//--- source/commutation_ctrl.sv
`timescale 1ns/100ps
`include "anpc_settings.svh"

module commutation_ctrl import anpc_state_pkg::*, anpc_timing_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  leg_state_t                 target,
    output logic                       ack,
    output logic                       rejected,
    output leg_state_t                 state,
    output logic [`SWITCH_COUNT-1:0]   gates,
    output leg_state_t                 from_state,
    output leg_state_t                 to_state,
    output logic [`STEP_WIDTH-1:0]     step,
    input  logic [`SWITCH_COUNT-1:0]   pattern,
    input  dwell_kind_t                kind,
    input  logic                       last,
    input  logic                       valid,
    output logic                       load,
    output dwell_kind_t                kind_sel,
    input  logic                       expired
);

    localparam logic [1:0] PH_IDLE  = 2'd0;  // Waiting for req
    localparam logic [1:0] PH_START = 2'd1;  // Target latched, pair checked
    localparam logic [1:0] PH_RUN   = 2'd2;  // Stepping through the sequence
    localparam logic [1:0] PH_DONE  = 2'd3;  // ack high until req falls

    logic [1:0]             phase;
    leg_state_t             target_q;
    logic [`STEP_WIDTH-1:0] step_q;    // Next step to load
    logic                   last_q;    // Shown pattern is the final one
    logic                   start_ok;  // Pair has a sequence and differs

    assign from_state = state;
    assign to_state   = target_q;
    assign step       = step_q;
    assign kind_sel   = kind;
    assign ack        = (phase == PH_DONE);

    assign start_ok = valid && (target_q != state);
    assign load     = ((phase == PH_START) && start_ok)
                   || ((phase == PH_RUN) && expired && !last_q);

    ////////////////////////////////////////////////////////////
    // Handshake and step sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= PH_IDLE;
            target_q <= Z_U2;
            state    <= Z_U2;
            step_q   <= '0;
            last_q   <= 1'b0;
            rejected <= 1'b0;
            gates    <= `RESET_GATES;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (req) begin
                        target_q <= target;
                        step_q   <= '0;
                        phase    <= PH_START;
                    end
                end
                PH_START: begin
                    rejected <= !valid && (target_q != state);  // Same state is no refusal
                    phase    <= start_ok ? PH_RUN : PH_DONE;
                end
                PH_RUN: begin
                    if (expired && last_q) begin
                        state <= target_q;  // Gates already hold the steady pattern
                        phase <= PH_DONE;
                    end
                end
                default: begin
                    if (!req) begin
                        rejected <= 1'b0;
                        phase    <= PH_IDLE;
                    end
                end
            endcase
            if (load) begin
                gates  <= pattern;
                last_q <= last;
                step_q <= step_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Protocol and switching checks
    ////////////////////////////////////////////////////////////

    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(req) |-> !ack);

    a_target_stable: assert property (@(posedge clk) disable iff (rst)
        (req && !ack && $past(req && !ack)) |-> $stable(target));

    // One switch at a time keeps every edge inside its dead time
    a_one_switch: assert property (@(posedge clk) disable iff (rst)
        $countones(gates ^ $past(gates)) <= 1);

endmodule

//--- source/dwell_timer.sv
`timescale 1ns/100ps
`include "anpc_settings.svh"

module dwell_timer import anpc_timing_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       load,
    input  dwell_kind_t                kind,
    input  logic [`TDELAY_WIDTH-1:0]   t_short,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_on,
    input  logic [`TDELAY_WIDTH-1:0]   t_on_off_v0,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_v0_on,
    input  logic [`TDELAY_WIDTH-1:0]   t_off_on_i0,
    output logic                       expired
);

    logic [`TDELAY_WIDTH-1:0] dwell_sel;  // Dwell for the requested kind
    logic [`TDELAY_WIDTH-1:0] count;      // Cycles left, zero when idle

    always_comb begin
        case (kind)
            OFF_ON:    dwell_sel = t_off_on;
            ON_OFF_V0: dwell_sel = t_on_off_v0;
            OFF_V0_ON: dwell_sel = t_off_v0_on;
            OFF_ON_I0: dwell_sel = t_off_on_i0;
            default:   dwell_sel = t_short;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= dwell_sel;  // A new load replaces a running dwell
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired = (count == `TDELAY_WIDTH'(1));  // Last cycle of the dwell

    // A zero dwell would never expire and stall the commutation
    a_dwell_nonzero: assert property (@(posedge clk) disable iff (rst)
        load |-> (dwell_sel != '0));

endmodule

//--- source/commutation_table.sv
`timescale 1ns/100ps
`include "anpc_settings.svh"

module commutation_table import anpc_state_pkg::*, anpc_timing_pkg::*; (
    input  leg_state_t                   from_state,
    input  leg_state_t                   to_state,
    input  logic [`STEP_WIDTH-1:0]       step,
    output logic [`SWITCH_COUNT-1:0]     pattern,
    output dwell_kind_t                  kind,
    output logic                         last,
    output logic                         valid
);

    localparam int KIND_BITS = $bits(dwell_kind_t);

    logic [`SWITCH_COUNT+KIND_BITS-1:0] entry;       // Pattern over dwell kind
    logic [`STEP_WIDTH-1:0]             final_step;  // Index of the steady pattern

    ////////////////////////////////////////////////////////////
    // Sequences keyed on target then source state
    ////////////////////////////////////////////////////////////

    always_comb begin
        entry      = '0;
        final_step = '0;
        valid      = 1'b1;
        case ({to_state, from_state})
            {P, Z_U2}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b010000, OFF_ON};  // s1 off
                    2'd1:    entry = {6'b110000, SHORT};
                    default: entry = {6'b110001, SHORT};
                endcase
            end
            {P, Z_U1}: begin
                final_step = 2'd3;
                case (step)
                    2'd0:    entry = {6'b010010, OFF_ON_I0};  // s2 off
                    2'd1:    entry = {6'b010011, SHORT};
                    2'd2:    entry = {6'b010001, OFF_ON};
                    default: entry = {6'b110001, SHORT};
                endcase
            end
            {P, Z_L1}: begin
                final_step = 2'd1;
                case (step)
                    2'd0:    entry = {6'b100001, OFF_ON};
                    default: entry = {6'b110001, SHORT};
                endcase
            end
            {P, Z_L2}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b011001, SHORT};
                    2'd1:    entry = {6'b010001, OFF_ON};
                    default: entry = {6'b110001, SHORT};
                endcase
            end
            {Z_U2, P}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b110000, SHORT};  // s0 off
                    2'd1:    entry = {6'b010000, OFF_ON};
                    default: entry = {6'b010010, SHORT};
                endcase
            end
            {Z_U2, N}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b001010, OFF_ON};
                    2'd1:    entry = {6'b011010, ON_OFF_V0};
                    default: entry = {6'b010010, ON_OFF_V0};
                endcase
            end
            {Z_U1, N}: begin
                final_step = 2'd1;
                case (step)
                    2'd0:    entry = {6'b000110, OFF_ON};
                    default: entry = {6'b010110, SHORT};
                endcase
            end
            {Z_L1, P}: begin
                final_step = 2'd1;
                case (step)
                    2'd0:    entry = {6'b100001, OFF_ON};
                    default: entry = {6'b101001, SHORT};
                endcase
            end
            {Z_L2, P}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b010001, OFF_ON};  // s5 off
                    2'd1:    entry = {6'b011001, ON_OFF_V0};
                    default: entry = {6'b001001, OFF_V0_ON};
                endcase
            end
            {Z_L2, N}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b001100, SHORT};
                    2'd1:    entry = {6'b001000, OFF_ON};
                    default: entry = {6'b001001, SHORT};
                endcase
            end
            {N, Z_U2}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b011010, SHORT};  // s3 on
                    2'd1:    entry = {6'b001010, OFF_ON};
                    default: entry = {6'b001110, SHORT};
                endcase
            end
            {N, Z_U1}: begin
                final_step = 2'd1;
                case (step)
                    2'd0:    entry = {6'b000110, OFF_ON};
                    default: entry = {6'b001110, SHORT};
                endcase
            end
            {N, Z_L1}: begin
                final_step = 2'd3;
                case (step)
                    2'd0:    entry = {6'b001001, OFF_ON_I0};
                    2'd1:    entry = {6'b001011, SHORT};
                    2'd2:    entry = {6'b001010, OFF_ON};
                    default: entry = {6'b001110, SHORT};
                endcase
            end
            {N, Z_L2}: begin
                final_step = 2'd2;
                case (step)
                    2'd0:    entry = {6'b001000, OFF_ON};
                    2'd1:    entry = {6'b001100, SHORT};
                    default: entry = {6'b001110, SHORT};
                endcase
            end
            default: valid = 1'b0;  // No sequence for this pair
        endcase
    end

    assign pattern = entry[`SWITCH_COUNT+KIND_BITS-1:KIND_BITS];
    assign kind    = dwell_kind_t'(entry[KIND_BITS-1:0]);
    assign last    = valid && (step == final_step);

endmodule

//--- source/anpc_timing_pkg.sv
package anpc_timing_pkg;

    // Which dead-time input a commutation step dwells on
    typedef enum logic [2:0] {
        SHORT     = 3'd0,  // Plain turn-on after a short gap
        OFF_ON    = 3'd1,  // Turn-off before a complementary turn-on
        ON_OFF_V0 = 3'd2,  // Clamp switch handover at zero voltage
        OFF_V0_ON = 3'd3,
        OFF_ON_I0 = 3'd4   // Zero current handover
    } dwell_kind_t;

endpackage

//--- source/anpc_state_pkg.sv
package anpc_state_pkg;

    ////////////////////////////////////////////////////////////
    // Leg states of one ANPC phase leg
    ////////////////////////////////////////////////////////////

    // Steady gate patterns are listed s5 down to s0
    typedef enum logic [2:0] {
        P    = 3'd0,  // 110001, output at positive rail
        Z_U2 = 3'd1,  // 010010, neutral through upper path
        Z_U1 = 3'd2,  // 010110
        Z_L1 = 3'd3,  // 101001
        Z_L2 = 3'd4,  // 001001, neutral through lower path
        N    = 3'd5   // 001110, output at negative rail
    } leg_state_t;

endpackage

//--- include/anpc_settings.svh
`ifndef ANPC_SETTINGS_SVH
`define ANPC_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Leg timing and gate sizing
////////////////////////////////////////////////////////////

`define TDELAY_WIDTH 8          // Dwell inputs and dwell counter
`define STEP_WIDTH   2          // Up to four steps per sequence
`define SWITCH_COUNT 6          // s0 to s5

`define RESET_GATES  6'b010010  // Z_U2 steady pattern

`endif
